//--- lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    // All-zero word decodes as BR with nzp 000
    localparam lc3b_word NOP_WORD = 16'h0000;
    localparam lc3b_word RESET_PC = 16'h0000;
    // Z flag set out of reset
    localparam lc3b_nzp  CC_RESET = 3'b010;

    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_jmp = 4'b1100
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    typedef enum logic [1:0] {
        alumux_reg,
        alumux_imm5,
        alumux_off6
    } lc3b_alumux_sel;

    typedef enum logic {
        rfmux_alu,
        rfmux_mem
    } lc3b_regfilemux_sel;

    typedef struct packed {
        lc3b_aluop      aluop;
        lc3b_alumux_sel alumux_sel;
    } lc3b_control_word_ex;

    typedef struct packed {
        logic d_mem_read;
        logic d_mem_write;
    } lc3b_control_word_mem;

    typedef struct packed {
        lc3b_opcode         opcode;
        logic               load_regfile;
        lc3b_regfilemux_sel regfilemux_sel;
        logic               load_cc;
    } lc3b_control_word_wb;

    typedef struct packed {
        logic                 src2mux_sel;
        lc3b_control_word_ex  ex;
        lc3b_control_word_mem mem;
        lc3b_control_word_wb  wb;
    } lc3b_control_word;

endpackage : lc3b_pkg

`default_nettype wire

//--- ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if
    import lc3b_pkg::*;
();

    // Decoded word for the instruction sitting in IF/ID
    lc3b_control_word cw;

    // Raw instruction fields the decoder needs
    lc3b_opcode       opcode;
    logic             ir_5;
    logic             ir_11;

    modport dec (
        input  opcode, ir_5, ir_11,
        output cw
    );

    modport dp (
        input  cw,
        output opcode, ir_5, ir_11
    );

endinterface : ctrl_if

`default_nettype wire

//--- pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load,
    input  logic     squash,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    // Squash wins over load so a redirect always empties the stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
        end else if (squash) begin
            valid_out <= 1'b0;
        end else if (load) begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_out <= data_in;
        end
    end

    // A valid entry never carries unknown bits into the next stage
    a_payload_known: assert property (@(posedge clk) disable iff (!arst_n)
        load && valid_in && !squash |-> !$isunknown(data_in));

endmodule : pipe_reg

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load,
    input  lc3b_reg  dest,
    input  lc3b_word in,
    input  lc3b_reg  src_a,
    input  lc3b_reg  src_b,
    output lc3b_word reg_a,
    output lc3b_word reg_b
);

    lc3b_word data [8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data <= '{default: '0};
        end else if (load) begin
            data[dest] <= in;
        end
    end

    // Write-through so a reader two slots behind the writer sees the new value
    assign reg_a = (load && dest == src_a) ? in : data[src_a];
    assign reg_b = (load && dest == src_b) ? in : data[src_b];

    a_dest_known: assert property (@(posedge clk) disable iff (!arst_n)
        load |-> !$isunknown(dest));

endmodule : regfile

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import lc3b_pkg::*;
(
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_and:  f = a & b;
            alu_not:  f = ~a;
            // Memory address already summed in front of the ALU
            alu_pass: f = b;
        endcase
    end

endmodule : alu

`default_nettype wire

//--- control_rom.sv
`timescale 1ns/1ps
`default_nettype none

module control_rom
    import lc3b_pkg::*;
(
    ctrl_if.dec ctrl
);

    lc3b_control_word cw;

    always_comb begin
        // Anything not listed stays all zero and behaves as a NOP
        cw = '0;
        case (ctrl.opcode)
            op_add, op_and: begin
                cw.ex.aluop        = (ctrl.opcode == op_add) ? alu_add : alu_and;
                // Bit 5 picks imm5 over the second source register
                cw.ex.alumux_sel   = ctrl.ir_5 ? alumux_imm5 : alumux_reg;
                cw.wb.opcode       = ctrl.opcode;
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc      = 1'b1;
            end
            op_not: begin
                cw.ex.aluop        = alu_not;
                cw.wb.opcode       = op_not;
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc      = 1'b1;
            end
            op_ldr: begin
                cw.ex.aluop          = alu_pass;
                cw.ex.alumux_sel     = alumux_off6;
                cw.mem.d_mem_read    = 1'b1;
                cw.wb.opcode         = op_ldr;
                cw.wb.load_regfile   = 1'b1;
                cw.wb.regfilemux_sel = rfmux_mem;
                cw.wb.load_cc        = 1'b1;
            end
            op_str: begin
                // Port B reads the register named in bits 11:9
                cw.src2mux_sel     = 1'b1;
                cw.ex.aluop        = alu_pass;
                cw.ex.alumux_sel   = alumux_off6;
                cw.mem.d_mem_write = 1'b1;
                cw.wb.opcode       = op_str;
            end
            op_br: begin
                cw.wb.opcode = op_br;
            end
            op_jmp: begin
                // Bits 11:9 are reserved zero in JMP
                if (!ctrl.ir_11) begin
                    // Base plus the zero imm5 field carries BaseR to WB
                    cw.ex.aluop      = alu_add;
                    cw.ex.alumux_sel = alumux_imm5;
                    cw.wb.opcode     = op_jmp;
                end
            end
            default: ;
        endcase
    end

    assign ctrl.cw = cw;

endmodule : control_rom

`default_nettype wire

//--- cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    ctrl_if.dp       ctrl,

    input  lc3b_word i_mem_rdata,
    output lc3b_word i_mem_address,

    input  logic     d_mem_resp,
    input  lc3b_word d_mem_rdata,
    output lc3b_word d_mem_address,
    output lc3b_word d_mem_wdata,
    output logic     d_mem_read,
    output logic     d_mem_write
);

    typedef struct packed {
        lc3b_control_word_ex  ex;
        lc3b_control_word_mem mem;
        lc3b_control_word_wb  wb;
        lc3b_word             pc_plus2;
        lc3b_word             src1_data;
        lc3b_word             src2_data;
        lc3b_reg              dest;
        lc3b_nzp              br_nzp;
        logic [8:0]           ir_low;
    } id_ex_t;

    typedef struct packed {
        lc3b_control_word_mem mem;
        lc3b_control_word_wb  wb;
        lc3b_word             pc_plus2;
        lc3b_word             alu_out;
        lc3b_word             store_data;
        lc3b_reg              dest;
        lc3b_nzp              br_nzp;
        logic [8:0]           offset9;
    } ex_mem_t;

    typedef struct packed {
        lc3b_control_word_wb wb;
        lc3b_word            pc_plus2;
        lc3b_word            alu_out;
        lc3b_word            mem_rdata;
        lc3b_reg             dest;
        lc3b_nzp             br_nzp;
        logic [8:0]          offset9;
    } mem_wb_t;

    logic     pipe_load;
    logic     redirect;
    logic     mem_active;
    lc3b_word pc;
    lc3b_word pc_plus2;
    lc3b_word pc_target;

    logic     if_id_valid;
    lc3b_word if_id_ir;
    lc3b_word if_id_pc_plus2;
    lc3b_reg  src2_sel;
    lc3b_word reg_a;
    lc3b_word reg_b;

    id_ex_t   id_ex_in;
    id_ex_t   id_ex;
    logic     id_ex_valid;
    lc3b_word imm5_sext;
    lc3b_word offset6_addr;
    lc3b_word alumux_out;
    lc3b_word alu_out;

    ex_mem_t  ex_mem_in;
    ex_mem_t  ex_mem;
    logic     ex_mem_valid;

    mem_wb_t  mem_wb_in;
    mem_wb_t  mem_wb;
    logic     mem_wb_valid;
    logic     wb_retire;
    lc3b_word regfilemux_out;
    lc3b_word br_target;
    lc3b_nzp  gencc;
    lc3b_nzp  cc;

    // Fetch
    assign pc_plus2      = pc + 16'd2;
    assign i_mem_address = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (pipe_load) begin
            pc <= redirect ? pc_target : pc_plus2;
        end
    end

    // IF/ID
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id_valid <= 1'b0;
            if_id_ir    <= NOP_WORD;
        end else if (redirect) begin
            if_id_valid <= 1'b0;
            if_id_ir    <= NOP_WORD;
        end else if (pipe_load) begin
            if_id_valid <= 1'b1;
            if_id_ir    <= i_mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_load) begin
            if_id_pc_plus2 <= pc_plus2;
        end
    end

    // Decode
    assign ctrl.opcode = lc3b_opcode'(if_id_ir[15:12]);
    assign ctrl.ir_5   = if_id_ir[5];
    assign ctrl.ir_11  = if_id_ir[11];
    assign src2_sel    = ctrl.cw.src2mux_sel ? if_id_ir[11:9] : if_id_ir[2:0];

    regfile i_regfile (
        .clk,
        .arst_n,
        .load  (wb_retire && mem_wb.wb.load_regfile),
        .dest  (mem_wb.dest),
        .in    (regfilemux_out),
        .src_a (if_id_ir[8:6]),
        .src_b (src2_sel),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    // Only a real BR carries condition bits, so undecoded words never branch
    assign id_ex_in = '{
        ex:        ctrl.cw.ex,
        mem:       ctrl.cw.mem,
        wb:        ctrl.cw.wb,
        pc_plus2:  if_id_pc_plus2,
        src1_data: reg_a,
        src2_data: reg_b,
        dest:      if_id_ir[11:9],
        br_nzp:    (ctrl.opcode == op_br) ? if_id_ir[11:9] : 3'b000,
        ir_low:    if_id_ir[8:0]
    };

    pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk, .arst_n, .load(pipe_load), .squash(redirect),
        .valid_in(if_id_valid), .data_in(id_ex_in),
        .valid_out(id_ex_valid), .data_out(id_ex)
    );

    // Execute
    assign imm5_sext    = {{11{id_ex.ir_low[4]}}, id_ex.ir_low[4:0]};
    assign offset6_addr = id_ex.src1_data + {{9{id_ex.ir_low[5]}}, id_ex.ir_low[5:0], 1'b0};

    always_comb begin
        case (id_ex.ex.alumux_sel)
            alumux_imm5: alumux_out = imm5_sext;
            alumux_off6: alumux_out = offset6_addr;
            default:     alumux_out = id_ex.src2_data;
        endcase
    end

    alu i_alu (
        .aluop (id_ex.ex.aluop),
        .a     (id_ex.src1_data),
        .b     (alumux_out),
        .f     (alu_out)
    );

    assign ex_mem_in = '{
        mem:        id_ex.mem,
        wb:         id_ex.wb,
        pc_plus2:   id_ex.pc_plus2,
        alu_out:    alu_out,
        store_data: id_ex.src2_data,
        dest:       id_ex.dest,
        br_nzp:     id_ex.br_nzp,
        offset9:    id_ex.ir_low
    };

    pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk, .arst_n, .load(pipe_load), .squash(redirect),
        .valid_in(id_ex_valid), .data_in(ex_mem_in),
        .valid_out(ex_mem_valid), .data_out(ex_mem)
    );

    // Memory
    // The MEM instruction is younger than a redirecting WB one and never starts
    assign mem_active    = ex_mem_valid && !redirect;
    assign d_mem_read    = mem_active && ex_mem.mem.d_mem_read;
    assign d_mem_write   = mem_active && ex_mem.mem.d_mem_write;
    assign d_mem_address = ex_mem.alu_out;
    assign d_mem_wdata   = ex_mem.store_data;

    // Whole pipe and PC hold until the data response
    assign pipe_load = !((d_mem_read || d_mem_write) && !d_mem_resp);

    assign mem_wb_in = '{
        wb:        ex_mem.wb,
        pc_plus2:  ex_mem.pc_plus2,
        alu_out:   ex_mem.alu_out,
        mem_rdata: d_mem_rdata,
        dest:      ex_mem.dest,
        br_nzp:    ex_mem.br_nzp,
        offset9:   ex_mem.offset9
    };

    pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk, .arst_n, .load(pipe_load), .squash(redirect),
        .valid_in(ex_mem_valid), .data_in(mem_wb_in),
        .valid_out(mem_wb_valid), .data_out(mem_wb)
    );

    // Write-back
    assign wb_retire      = mem_wb_valid && pipe_load;
    assign regfilemux_out = (mem_wb.wb.regfilemux_sel == rfmux_mem) ? mem_wb.mem_rdata
                                                                     : mem_wb.alu_out;
    assign gencc = regfilemux_out[15]       ? 3'b100 :
                   (regfilemux_out == '0)   ? 3'b010 : 3'b001;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cc <= CC_RESET;
        end else if (wb_retire && mem_wb.wb.load_cc) begin
            cc <= gencc;
        end
    end

    assign br_target = mem_wb.pc_plus2 + {{6{mem_wb.offset9[8]}}, mem_wb.offset9, 1'b0};

    // Branches and JMP resolve here
    always_comb begin
        redirect  = 1'b0;
        pc_target = br_target;
        if (mem_wb_valid) begin
            case (mem_wb.wb.opcode)
                op_br:   redirect = |(mem_wb.br_nzp & cc);
                op_jmp: begin
                    redirect  = 1'b1;
                    pc_target = mem_wb.alu_out;
                end
                default: ;
            endcase
        end
    end

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(d_mem_read && d_mem_write));

    a_request_held: assert property (@(posedge clk) disable iff (!arst_n)
        (d_mem_read || d_mem_write) && !d_mem_resp
        |=> $stable(d_mem_address) && $stable({d_mem_read, d_mem_write}));

endmodule : cpu_datapath

`default_nettype wire

//--- lc3b_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    output lc3b_word i_mem_address,
    input  lc3b_word i_mem_rdata,

    output logic     d_mem_read,
    output logic     d_mem_write,
    output lc3b_word d_mem_address,
    output lc3b_word d_mem_wdata,
    input  lc3b_word d_mem_rdata,
    input  logic     d_mem_resp
);

    ctrl_if i_ctrl ();

    control_rom i_control_rom (
        .ctrl (i_ctrl.dec)
    );

    cpu_datapath i_datapath (
        .clk,
        .arst_n,
        .ctrl          (i_ctrl.dp),
        .i_mem_rdata   (i_mem_rdata),
        .i_mem_address (i_mem_address),
        .d_mem_resp    (d_mem_resp),
        .d_mem_rdata   (d_mem_rdata),
        .d_mem_address (d_mem_address),
        .d_mem_wdata   (d_mem_wdata),
        .d_mem_read    (d_mem_read),
        .d_mem_write   (d_mem_write)
    );

endmodule : lc3b_cpu

`default_nettype wire

//--- tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem
    import lc3b_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic [7:0][15:0] prog,
    input  lc3b_word         preset_addr,
    input  lc3b_word         preset_data,
    input  lc3b_word         i_mem_address,
    output lc3b_word         i_mem_rdata,
    input  logic             d_mem_read,
    input  logic             d_mem_write,
    input  lc3b_word         d_mem_address,
    input  lc3b_word         d_mem_wdata,
    output lc3b_word         d_mem_rdata,
    output logic             d_mem_resp,
    output int               store_count,
    output lc3b_word         store_addr,
    output lc3b_word         store_data
);

    lc3b_word   dmem [64];
    logic       busy;
    logic [1:0] wait_left;

    initial begin
        void'($urandom(32'h5488_3139));
    end

    // Program sits in the first eight words and everything above reads as NOP
    // Word 0 is the leftmost word of the program row
    assign i_mem_rdata = (i_mem_address[15:4] == '0) ? prog[3'd7 - i_mem_address[3:1]]
                                                      : NOP_WORD;
    assign d_mem_rdata = dmem[d_mem_address[6:1]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= lc3b_word'(i * 2) ^ 16'hA500;
            end
            dmem[preset_addr[6:1]] <= preset_data;
            busy        <= 1'b0;
            wait_left   <= 2'd0;
            d_mem_resp  <= 1'b0;
            store_count <= 0;
            store_addr  <= '0;
            store_data  <= '0;
        end else begin
            d_mem_resp <= 1'b0;
            if (d_mem_resp) begin
                // Request completes at this edge
                busy <= 1'b0;
                if (d_mem_write) begin
                    dmem[d_mem_address[6:1]] <= d_mem_wdata;
                    store_count              <= store_count + 1;
                    store_addr               <= d_mem_address;
                    store_data               <= d_mem_wdata;
                end
            end else if (busy) begin
                if (wait_left == 2'd0) begin
                    d_mem_resp <= 1'b1;
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end else if (d_mem_read || d_mem_write) begin
                // New request answered after one to three cycles
                busy      <= 1'b1;
                wait_left <= 2'($urandom_range(2, 0));
            end
        end
    end

endmodule : tb_mem

`default_nettype wire

//--- tb_lc3b_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc3b_cpu
    import lc3b_pkg::*;
();

    localparam int N_TESTS         = 8;
    localparam int CYCLES_PER_TEST = 200;
    localparam int TIMEOUT_CYCLES  = N_TESTS * CYCLES_PER_TEST;
    localparam int SETTLE_CYCLES   = 8;

    logic             clk;
    logic             arst_n;
    logic [7:0][15:0] prog;
    lc3b_word         preset_addr;
    lc3b_word         preset_data;
    lc3b_word         i_mem_address;
    lc3b_word         i_mem_rdata;
    logic             d_mem_read;
    logic             d_mem_write;
    lc3b_word         d_mem_address;
    lc3b_word         d_mem_wdata;
    lc3b_word         d_mem_rdata;
    logic             d_mem_resp;
    int               store_count;
    lc3b_word         store_addr;
    lc3b_word         store_data;

    string            row_name     [N_TESTS];
    logic [7:0][15:0] row_prog     [N_TESTS];
    lc3b_word         row_paddr    [N_TESTS];
    lc3b_word         row_pdata    [N_TESTS];
    lc3b_word         row_exp_addr [N_TESTS];
    lc3b_word         row_exp_data [N_TESTS];

    int errors;
    int failed;
    int cycle_count = 0;

    lc3b_cpu i_dut (
        .clk, .arst_n,
        .i_mem_address, .i_mem_rdata,
        .d_mem_read, .d_mem_write, .d_mem_address, .d_mem_wdata,
        .d_mem_rdata, .d_mem_resp
    );

    tb_mem i_mem (
        .clk, .arst_n, .prog, .preset_addr, .preset_data,
        .i_mem_address, .i_mem_rdata,
        .d_mem_read, .d_mem_write, .d_mem_address, .d_mem_wdata,
        .d_mem_rdata, .d_mem_resp,
        .store_count, .store_addr, .store_data
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with no store completing", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic set_row(input int r, input string name, input logic [7:0][15:0] words,
                           input lc3b_word paddr, input lc3b_word pdata,
                           input lc3b_word eaddr, input lc3b_word edata);
        row_name[r]     = name;
        row_prog[r]     = words;
        row_paddr[r]    = paddr;
        row_pdata[r]    = pdata;
        row_exp_addr[r] = eaddr;
        row_exp_data[r] = edata;
    endtask

    // Each row holds program words 0..7, preset addr, preset data, store addr and store data
    task automatic fill_table();
        // 5 + 7 through a register ADD
        set_row(0, "add_reg",
                {16'h1225, 16'h1427, 16'h0000, 16'h0000, 16'h1642, 16'h0000, 16'h0000, 16'h760A},
                16'h0030, 16'h0000, 16'h0014, 16'h000C);
        // 0xFFFF AND #-3
        set_row(1, "and_imm",
                {16'h123F, 16'h0000, 16'h0000, 16'h547D, 16'h0000, 16'h0000, 16'h740B, 16'h0000},
                16'h0030, 16'h0000, 16'h0016, 16'hFFFD);
        set_row(2, "and_reg",
                {16'h122C, 16'h142A, 16'h0000, 16'h0000, 16'h5642, 16'h0000, 16'h0000, 16'h760C},
                16'h0030, 16'h0000, 16'h0018, 16'h0008);
        set_row(3, "not",
                {16'h1229, 16'h0000, 16'h0000, 16'h987F, 16'h0000, 16'h0000, 16'h780D, 16'h0000},
                16'h0030, 16'h0000, 16'h001A, 16'hFFF6);
        // Loaded word plus 3
        set_row(4, "ldr_stall",
                {16'h6218, 16'h0000, 16'h0000, 16'h1463, 16'h0000, 16'h0000, 16'h740E, 16'h0000},
                16'h0030, 16'h1234, 16'h001C, 16'h1237);
        // BRn skips three increments of R1
        set_row(5, "br_taken",
                {16'h1226, 16'h143E, 16'h0803, 16'h1261, 16'h1261, 16'h1261, 16'h720F, 16'h0000},
                16'h0030, 16'h0000, 16'h001E, 16'h0006);
        // BRnz on a positive CC falls through to the ADD
        set_row(6, "br_not_taken",
                {16'h1224, 16'h0000, 16'h0000, 16'h0C02, 16'h1665, 16'h0000, 16'h0000, 16'h7610},
                16'h0030, 16'h0000, 16'h0020, 16'h0009);
        // STR right behind the JMP never reaches memory
        set_row(7, "jmp",
                {16'h1A2C, 16'h1423, 16'h0000, 16'hC140, 16'h7401, 16'h0000, 16'h7542, 16'h0000},
                16'h0030, 16'h0000, 16'h0010, 16'h0003);
    endtask

    task automatic check_word(input string what, input lc3b_word actual, input lc3b_word expected);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_count(input string what, input int actual, input int expected);
        if (actual != expected) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic run_test(input int r);
        int errors_before;
        errors_before = errors;
        @(negedge clk);
        prog        = row_prog[r];
        preset_addr = row_paddr[r];
        preset_data = row_pdata[r];
        arst_n      = 1'b0;
        repeat (2) @(negedge clk);
        if (d_mem_read || d_mem_write) begin
            errors++;
            $display("Data memory strobe high during reset at %0t", $time);
        end
        arst_n = 1'b1;
        // First cycle out of reset fetches from address zero
        check_word("i_mem_address", i_mem_address, 16'h0000);
        while (store_count == 0) begin
            @(negedge clk);
        end
        check_word("store_addr", store_addr, row_exp_addr[r]);
        check_word("store_data", store_data, row_exp_data[r]);
        repeat (SETTLE_CYCLES) @(negedge clk);
        check_count("store_count", store_count, 1);
        if (errors == errors_before) begin
            $display("test %0d %s: ok", r, row_name[r]);
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", r, row_name[r], errors - errors_before);
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        prog        = '0;
        preset_addr = '0;
        preset_data = '0;
        errors      = 0;
        failed      = 0;
        fill_table();
        for (int r = 0; r < N_TESTS; r++) begin
            run_test(r);
        end
        $display("tests %0d, failed %0d, errors %0d", N_TESTS, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_lc3b_cpu

`default_nettype wire

//--- all.f
lc3b_pkg.sv
ctrl_if.sv
pipe_reg.sv
regfile.sv
alu.sv
control_rom.sv
cpu_datapath.sv
lc3b_cpu.sv
tb_mem.sv
tb_lc3b_cpu.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_lc3b_cpu \
    -f all.f \
    -o sim_lc3b_cpu

./obj_dir/sim_lc3b_cpu > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
